// ==== all.f ====
+incdir+hdl
hdl/port_parser_pkg.sv
hdl/beat_tracker.sv
hdl/field_extractor.sv
hdl/port_acl.sv
hdl/checksum_detect.sv
hdl/header_status.sv
hdl/port_parser_top.sv
verif/port_parser_tb.sv

// ==== hdl/beat_tracker.sv ====
`timescale 1ns/1ps

module beat_tracker
    import port_parser_pkg::*;
(
    input  logic                 aclk,
    input  logic                 reset,

    // Stream handshake and framing
    input  logic                 in_valid,
    input  logic                 out_ready,
    input  logic                 in_last,

    // Beat events
    output logic                 accepted,
    output logic                 last_accepted,

    // Byte position of the beat now on the bus
    output logic [POS_WIDTH-1:0] position
);

    localparam logic [POS_WIDTH-1:0] BEAT_STEP = POS_WIDTH'(BUS_BYTES);

    // A beat moves only when both sides agree
    assign accepted      = in_valid & out_ready;
    assign last_accepted = accepted & in_last;

    // First beat of a packet sits at byte 0
    always_ff @(posedge aclk) begin
        if (reset || last_accepted) begin
            position <= '0;
        end else if (accepted) begin
            position <= position + BEAT_STEP;
        end
    end

endmodule

// ==== hdl/checksum_detect.sv ====
`timescale 1ns/1ps

module checksum_detect
    import port_parser_pkg::*;
(
    input  logic   aclk,
    input  logic   reset,
    input  field_t field,
    input  logic   can_have_udp_check,
    input  logic   last_accepted,
    output logic   has_udp_checksum
);

    logic cur_nonzero;
    logic stored_nonzero;
    logic checksum_seen;

    // A zero UDP checksum means the sender did not compute one
    assign cur_nonzero = (field.value != 16'h0000);

    always_ff @(posedge aclk) begin
        if (reset || last_accepted) begin
            stored_nonzero <= 1'b0;
        end else if (field.present) begin
            stored_nonzero <= cur_nonzero;
        end
    end

    assign checksum_seen    = field.present ? cur_nonzero : stored_nonzero;

    // Not UDP, so no checksum to report
    assign has_udp_checksum = can_have_udp_check & checksum_seen;

endmodule

// ==== hdl/field_extractor.sv ====
`timescale 1ns/1ps

`include "port_parser_settings.svh"

module field_extractor
    import port_parser_pkg::*;
#(
    // Base byte offset, must be even
    parameter int FIELD_OFFSET = 0
)
(
    input  logic [`PP_BUS_WIDTH-1:0] data,
    input  logic [POS_WIDTH-1:0]     position,
    input  logic [OFS_WIDTH-1:0]     added_offset,
    input  logic                     accepted,
    output field_t                   field
);

    localparam int BYTE_BITS = $clog2(BUS_BYTES);
    localparam int NUM_LANES = BUS_BYTES / 2;

    logic [POS_WIDTH-1:0]   field_addr;
    logic [BYTE_BITS-2:0]   lane_sel;
    logic [15:0]            lanes [NUM_LANES];

    // Split the bus into 16-bit lanes
    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lanes
        assign lanes[i] = data[16*i +: 16];
    end

    // Byte address of the field with IP options taken into account
    assign field_addr = POS_WIDTH'(FIELD_OFFSET) + POS_WIDTH'(added_offset);

    // Low bits pick the lane, upper bits pick the beat
    assign lane_sel = field_addr[BYTE_BITS-1:1];

    assign field.value   = lanes[lane_sel];
    assign field.present = accepted &&
        (field_addr[POS_WIDTH-1:BYTE_BITS] == position[POS_WIDTH-1:BYTE_BITS]);

endmodule

// ==== hdl/header_status.sv ====
`timescale 1ns/1ps

module header_status
    import port_parser_pkg::*;
(
    input  logic     aclk,
    input  logic     reset,

    // ACL results
    input  logic     src_violation,
    input  logic     dest_violation,

    // Destination port is the last field this stage needs
    input  logic     dest_present,

    input  side_in_t side_in,
    input  logic     last_accepted,

    output logic     poisoned,
    output logic     parsing_done
);

    logic dest_seen;
    logic ports_done;

    // Sticky until the end of the packet
    always_ff @(posedge aclk) begin
        if (reset || last_accepted) begin
            dest_seen <= 1'b0;
        end else if (dest_present) begin
            dest_seen <= 1'b1;
        end
    end

    assign ports_done = dest_present | dest_seen;

    // ACLs only count when the packet carries ports
    assign poisoned = side_in.poisoned |
        (side_in.has_ports & (src_violation | dest_violation));

    // Without ports the upstream stage decides when parsing ends
    assign parsing_done = side_in.has_ports ? ports_done : side_in.parsing_done;

endmodule

// ==== hdl/port_acl.sv ====
`timescale 1ns/1ps

module port_acl
    import port_parser_pkg::*;
(
    input  logic       aclk,
    input  logic       reset,

    // Extracted port and the rule it is checked against
    input  field_t     field,
    input  port_rule_t rule,

    input  logic       last_accepted,
    output logic       violation
);

    logic cur_violation;
    logic violation_seen;

    // Only an enabled rule can reject a port
    assign cur_violation = field.present && rule.enable && (field.value != rule.port);

    // Remember a mismatch until the packet ends
    always_ff @(posedge aclk) begin
        if (reset || last_accepted) begin
            violation_seen <= 1'b0;
        end else if (cur_violation) begin
            violation_seen <= 1'b1;
        end
    end

    // Visible in the same cycle as the offending beat
    assign violation = cur_violation | violation_seen;

endmodule

// ==== hdl/port_parser_pkg.sv ====
`include "port_parser_settings.svh"

package port_parser_pkg;

    // Byte position within a packet
    localparam int POS_WIDTH = $clog2(`PP_MAX_PACKET_LENGTH + 1);
    // IP option offset from the IPv4 stage
    localparam int OFS_WIDTH = $clog2(`PP_MAX_ADDED_OFFSET + 1);
    localparam int BUS_BYTES = `PP_BUS_WIDTH / 8;

    typedef struct packed {
        logic [`PP_BUS_WIDTH-1:0] data;
        logic [BUS_BYTES-1:0]     keep;
        logic                     last;
    } stream_beat_t;

    // Present only in the accepted beat that carries the field
    typedef struct packed {
        logic [15:0] value;
        logic        present;
    } field_t;

    typedef struct packed {
        logic [15:0] port;
        logic        enable;
    } port_rule_t;

    typedef struct packed {
        logic                 poisoned;
        logic                 parsing_done;
        logic                 has_ports;
        logic                 can_have_udp_check;
        logic [OFS_WIDTH-1:0] added_offset;
    } side_in_t;

    typedef struct packed {
        logic poisoned;
        logic parsing_done;
        logic has_udp_checksum;
    } side_out_t;

endpackage

// ==== hdl/port_parser_settings.svh ====
`ifndef PORT_PARSER_SETTINGS_SVH
`define PORT_PARSER_SETTINGS_SVH

// Stream data bus width in bits
`define PP_BUS_WIDTH 64

// Base byte offsets of the UDP/TCP header fields
// before any IP options are added
`define PP_SPORT_OFFSET 34
`define PP_DPORT_OFFSET 36
`define PP_CHECK_OFFSET 40

// Packet limits
`define PP_MAX_PACKET_LENGTH 1522

// Largest IP option offset the IPv4 stage can report
`define PP_MAX_ADDED_OFFSET 64

`endif

// ==== hdl/port_parser_top.sv ====
`timescale 1ns/1ps

`include "port_parser_settings.svh"

module port_parser_top
    import port_parser_pkg::*;
(
    input  logic         aclk,
    input  logic         reset,

    // Input stream
    input  stream_beat_t in_beat,
    input  logic         in_valid,
    output logic         in_ready,

    // Output stream
    output stream_beat_t out_beat,
    output logic         out_valid,
    input  logic         out_ready,

    // Side information in and results out
    input  side_in_t     side_in,
    output side_out_t    side_out,

    // Access rules
    input  port_rule_t   src_rule,
    input  port_rule_t   dest_rule
);

    logic                 accepted;
    logic                 last_accepted;
    logic [POS_WIDTH-1:0] position;

    field_t src_field;
    field_t dest_field;
    field_t check_field;

    logic src_violation;
    logic dest_violation;

    // Stream is not touched by this stage
    assign out_beat  = in_beat;
    assign out_valid = in_valid;
    assign in_ready  = out_ready;

    beat_tracker beat_tracker_i (
        .aclk          (aclk),
        .reset         (reset),
        .in_valid      (in_valid),
        .out_ready     (out_ready),
        .in_last       (in_beat.last),
        .accepted      (accepted),
        .last_accepted (last_accepted),
        .position      (position)
    );

    field_extractor #(.FIELD_OFFSET(`PP_SPORT_OFFSET)) sport_extractor_i (
        .data         (in_beat.data),
        .position     (position),
        .added_offset (side_in.added_offset),
        .accepted     (accepted),
        .field        (src_field)
    );

    field_extractor #(.FIELD_OFFSET(`PP_DPORT_OFFSET)) dport_extractor_i (
        .data         (in_beat.data),
        .position     (position),
        .added_offset (side_in.added_offset),
        .accepted     (accepted),
        .field        (dest_field)
    );

    field_extractor #(.FIELD_OFFSET(`PP_CHECK_OFFSET)) check_extractor_i (
        .data         (in_beat.data),
        .position     (position),
        .added_offset (side_in.added_offset),
        .accepted     (accepted),
        .field        (check_field)
    );

    port_acl src_acl_i (
        .aclk          (aclk),
        .reset         (reset),
        .field         (src_field),
        .rule          (src_rule),
        .last_accepted (last_accepted),
        .violation     (src_violation)
    );

    port_acl dest_acl_i (
        .aclk          (aclk),
        .reset         (reset),
        .field         (dest_field),
        .rule          (dest_rule),
        .last_accepted (last_accepted),
        .violation     (dest_violation)
    );

    checksum_detect checksum_detect_i (
        .aclk               (aclk),
        .reset              (reset),
        .field              (check_field),
        .can_have_udp_check (side_in.can_have_udp_check),
        .last_accepted      (last_accepted),
        .has_udp_checksum   (side_out.has_udp_checksum)
    );

    header_status header_status_i (
        .aclk           (aclk),
        .reset          (reset),
        .src_violation  (src_violation),
        .dest_violation (dest_violation),
        .dest_present   (dest_field.present),
        .side_in        (side_in),
        .last_accepted  (last_accepted),
        .poisoned       (side_out.poisoned),
        .parsing_done   (side_out.parsing_done)
    );

endmodule

// ==== verif/port_parser_tb.sv ====
`timescale 1ns/1ps

`include "port_parser_settings.svh"

module port_parser_tb
    import port_parser_pkg::*;
();

    localparam int MAX_BEATS = 14;
    localparam int RESET_CYCLES = 10;
    localparam int SMOOTH_PACKETS = 100;
    localparam int STALL_PACKETS = 200;
    localparam int CLEAR_PAIRS = 20;
    localparam int NO_PORT_PACKETS = 60;
    localparam int TOTAL_PACKETS = SMOOTH_PACKETS + STALL_PACKETS + 2 * CLEAR_PAIRS +
        NO_PORT_PACKETS;
    // Every beat may take up to four cycles under back-pressure
    localparam longint TIMEOUT_NS = longint'(TOTAL_PACKETS) * MAX_BEATS * 4 * 100 +
        RESET_CYCLES * 100;

    logic         aclk;
    logic         reset;
    stream_beat_t in_beat;
    logic         in_valid;
    logic         in_ready;
    stream_beat_t out_beat;
    logic         out_valid;
    logic         out_ready;
    side_in_t     side_in;
    side_out_t    side_out;
    port_rule_t   src_rule;
    port_rule_t   dest_rule;

    // Packet bytes as the model sees them
    logic [7:0] pkt [MAX_BEATS*8];

    int error_count;
    int check_count;
    int test_count;
    int test_errors_at_start;
    int test_checks_at_start;

    port_parser_top dut_i (
        .aclk      (aclk),
        .reset     (reset),
        .in_beat   (in_beat),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_beat  (out_beat),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .side_in   (side_in),
        .side_out  (side_out),
        .src_rule  (src_rule),
        .dest_rule (dest_rule)
    );

    always #50 aclk = ~aclk;

    task automatic compare(input string name, input logic [79:0] expected,
                           input logic [79:0] actual);
        check_count++;
        if (expected !== actual) begin
            error_count++;
            $display("Error: %s expected %h, got %h", name, expected, actual);
        end
    endtask

    // Stream passes straight through on every cycle
    always @(negedge aclk) begin
        if (!reset) begin
            compare("out_beat", in_beat, out_beat);
            compare("out_valid", in_valid, out_valid);
            compare("in_ready", out_ready, in_ready);
        end
    end

    // Field bytes in wire order, first byte in the low half
    function automatic logic [15:0] field_value(input int addr);
        return {pkt[addr+1], pkt[addr]};
    endfunction

    // True once the beat holding the field has been accepted
    function automatic bit field_counted(input int addr, input int beat, input bit accepted);
        return (addr / 8 < beat) || ((addr / 8 == beat) && accepted);
    endfunction

    // Mode 1 forces a mismatch, mode 2 a match, anything else is random
    function automatic port_rule_t make_rule(input int mode, input logic [15:0] value);
        port_rule_t r;
        case (mode)
            1: begin
                r.enable = 1'b1;
                r.port   = ~value;
            end
            2: begin
                r.enable = 1'b1;
                r.port   = value;
            end
            default: begin
                r.enable = ($urandom % 4) != 0;
                r.port   = ($urandom % 2) ? value : 16'($urandom);
            end
        endcase
        return r;
    endfunction

    task automatic run_packet(input int nbeats, input int rule_mode, input bit ports,
                              input bit stalls);
        int           plen;
        int           ofs;
        int           s_addr;
        int           d_addr;
        int           c_addr;
        bit           s_in;
        bit           d_in;
        bit           c_in;
        bit           s_viol;
        bit           d_viol;
        bit           c_nonzero;
        bit           s_seen;
        bit           d_seen;
        bit           c_seen;
        bit           done;
        side_in_t     si;
        port_rule_t   sr;
        port_rule_t   dr;
        side_out_t    expected;
        stream_beat_t beat;

        plen = nbeats * 8;
        for (int i = 0; i < plen; i++) begin
            pkt[i] = 8'($urandom);
        end
        ofs    = 4 * ($urandom % 11);
        s_addr = `PP_SPORT_OFFSET + ofs;
        d_addr = `PP_DPORT_OFFSET + ofs;
        c_addr = `PP_CHECK_OFFSET + ofs;
        s_in   = (s_addr + 2) <= plen;
        d_in   = (d_addr + 2) <= plen;
        c_in   = (c_addr + 2) <= plen;

        // A zero checksum is common on real UDP traffic
        if (c_in && ($urandom % 3) == 0) begin
            pkt[c_addr]   = 8'h00;
            pkt[c_addr+1] = 8'h00;
        end

        si.poisoned           = ($urandom % 8) == 0;
        si.parsing_done       = $urandom % 2;
        si.has_ports          = ports;
        si.can_have_udp_check = ($urandom % 4) != 0;
        si.added_offset       = OFS_WIDTH'(ofs);
        sr = make_rule(rule_mode, field_value(s_addr));
        dr = make_rule(rule_mode, field_value(d_addr));

        s_viol    = s_in && sr.enable && (field_value(s_addr) != sr.port);
        d_viol    = d_in && dr.enable && (field_value(d_addr) != dr.port);
        c_nonzero = c_in && (field_value(c_addr) != 16'h0000);

        side_in   <= si;
        src_rule  <= sr;
        dest_rule <= dr;
        for (int b = 0; b < nbeats; b++) begin
            for (int k = 0; k < 8; k++) begin
                beat.data[8*k +: 8] = pkt[8*b + k];
            end
            beat.keep = '1;
            beat.last = (b == nbeats - 1);
            in_beat   <= beat;
            in_valid  <= 1'b1;
            out_ready <= stalls ? (($urandom % 4) != 0) : 1'b1;
            do begin
                @(negedge aclk);
                done = out_ready;
                // Results so far, with this beat only once it is accepted
                s_seen = s_in && field_counted(s_addr, b, done);
                d_seen = d_in && field_counted(d_addr, b, done);
                c_seen = c_in && field_counted(c_addr, b, done);
                expected.poisoned         = si.poisoned |
                    (si.has_ports & ((s_seen & s_viol) | (d_seen & d_viol)));
                expected.has_udp_checksum = si.can_have_udp_check & c_seen & c_nonzero;
                expected.parsing_done     = si.has_ports ? d_seen : si.parsing_done;
                compare("side_out.poisoned", expected.poisoned, side_out.poisoned);
                compare("side_out.parsing_done", expected.parsing_done,
                        side_out.parsing_done);
                compare("side_out.has_udp_checksum", expected.has_udp_checksum,
                        side_out.has_udp_checksum);
                @(posedge aclk);
                if (!done) begin
                    out_ready <= ($urandom % 4) != 0;
                end
            end while (!done);
        end

        // Short idle gap between packets
        repeat ($urandom % 3) begin
            in_valid  <= 1'b0;
            in_beat   <= stream_beat_t'({$urandom, $urandom, $urandom});
            out_ready <= $urandom % 2;
            @(posedge aclk);
        end
    endtask

    task automatic start_test();
        test_errors_at_start = error_count;
        test_checks_at_start = check_count;
    endtask

    task automatic finish_test(input string name);
        test_count++;
        $display("Test %0d %s: %0d checks, %0d errors", test_count, name,
                 check_count - test_checks_at_start, error_count - test_errors_at_start);
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("Test failures found");
        $finish;
    end

    initial begin
        void'($urandom(32'haf71));
        error_count = 0;
        check_count = 0;
        test_count  = 0;
        aclk        = 1'b0;
        reset       = 1'b1;
        in_beat     = '0;
        in_valid    = 1'b0;
        out_ready   = 1'b0;
        side_in     = '0;
        src_rule    = '0;
        dest_rule   = '0;
        repeat (RESET_CYCLES) @(posedge aclk);
        reset <= 1'b0;

        start_test();
        for (int i = 0; i < SMOOTH_PACKETS; i++) begin
            run_packet(1 + $urandom % MAX_BEATS, 0, 1'b1, 1'b0);
        end
        finish_test("ports without stalls");

        start_test();
        for (int i = 0; i < STALL_PACKETS; i++) begin
            run_packet(1 + $urandom % MAX_BEATS, 0, ($urandom % 4) != 0, 1'b1);
        end
        finish_test("random back-pressure");

        // Long violating packet, then a short clean one
        start_test();
        for (int i = 0; i < CLEAR_PAIRS; i++) begin
            run_packet(MAX_BEATS, 1, 1'b1, 1'b1);
            run_packet(1 + $urandom % 5, 2, 1'b1, 1'b1);
        end
        finish_test("per-packet clearing");

        start_test();
        for (int i = 0; i < NO_PORT_PACKETS; i++) begin
            run_packet(1 + $urandom % MAX_BEATS, 0, 1'b0, 1'b1);
        end
        finish_test("packets without ports");

        $display("Summary: %0d tests, %0d checks, %0d errors", test_count, check_count,
                 error_count);
        if (error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule
